// ==== flist.f ====
verilog/vid_bus_pkg.sv
verilog/vid_gfx_pkg.sv
verilog/gfx_chip_regs.sv
verilog/palette_ram.sv
verilog/snap_loader.sv
verilog/vid_snap_top.sv
verification/vid_snap_tb.sv

// ==== verification/vid_snap_tb.sv ====
// Testbench for vid_snap_top that models the snapshot memory, runs host traffic and checks a model
module vid_snap_tb;

    localparam int VRAM_AW  = 8;
    localparam int SNAP_AW  = 10;                   // 1024 bytes covers the snapshot
    localparam int V        = 2 ** VRAM_AW;         // VRAM bytes per chip
    localparam int PAL_LEN  = 256;
    localparam int N        = 2 * V + PAL_LEN + vid_bus_pkg::SNAP_CFG_BYTES;
    localparam int CFG_BASE = 2 * V + PAL_LEN;      // First config byte in the snapshot
    localparam int NUM_COLOR = 64;
    localparam int NUM_RAND  = 1500;
    localparam int NUM_OPS   = 2 * V + 16 + PAL_LEN + NUM_COLOR + NUM_RAND;
    localparam int TIMEOUT_CYCLES = N + 4 * NUM_OPS + 100;

    logic                   clk;
    logic                   rst;
    logic [SNAP_AW-1:0]     snap_addr;
    vid_bus_pkg::byte_t     snap_data;
    vid_bus_pkg::cpu_addr_t host_addr;
    vid_bus_pkg::byte_t     host_wdata;
    logic                   host_we;
    logic                   host_rd;
    logic                   host_gfx1_vram_cs;
    logic                   host_gfx2_vram_cs;
    logic                   host_gfx1_cfg_cs;
    logic                   host_gfx2_cfg_cs;
    logic                   host_pal_cs;
    vid_bus_pkg::byte_t     host_rdata;
    logic                   done;
    vid_gfx_pkg::pal_idx_t  pal_idx;
    vid_gfx_pkg::color_t    color;

    vid_bus_pkg::byte_t snap_mem [0:2**SNAP_AW-1];  // Snapshot image outside the DUT

    // Reference model of the video state
    vid_bus_pkg::byte_t model_vram1 [0:V-1];
    vid_bus_pkg::byte_t model_vram2 [0:V-1];
    vid_bus_pkg::byte_t model_cfg1  [0:7];
    vid_bus_pkg::byte_t model_cfg2  [0:7];
    vid_bus_pkg::byte_t model_pal   [0:PAL_LEN-1];

    logic [31:0] rng;                               // Xorshift state

    vid_snap_top #(
        .VRAM_AW (VRAM_AW),
        .SNAP_AW (SNAP_AW)
    ) vid_snap_top_i (
        .clk               (clk),
        .rst               (rst),
        .snap_addr         (snap_addr),
        .snap_data         (snap_data),
        .host_addr         (host_addr),
        .host_wdata        (host_wdata),
        .host_we           (host_we),
        .host_rd           (host_rd),
        .host_gfx1_vram_cs (host_gfx1_vram_cs),
        .host_gfx2_vram_cs (host_gfx2_vram_cs),
        .host_gfx1_cfg_cs  (host_gfx1_cfg_cs),
        .host_gfx2_cfg_cs  (host_gfx2_cfg_cs),
        .host_pal_cs       (host_pal_cs),
        .host_rdata        (host_rdata),
        .done              (done),
        .pal_idx           (pal_idx),
        .color             (color)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                      // Period 8
    end

    // Snapshot memory with one cycle of read latency
    always @(posedge clk) begin
        snap_data <= snap_mem[snap_addr];
    end

    // Watchdog sized from the snapshot length and the host operation count
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: done never rose or the host tests did not finish");
        $display("test failed");
        $fatal(1);
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s got %0h expected %0h", name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // Target codes 0 chip 1 VRAM, 1 chip 2 VRAM, 2 chip 1 config, 3 chip 2 config, 4 palette
    function automatic vid_bus_pkg::byte_t model_read(input int target,
                                                      input vid_bus_pkg::cpu_addr_t addr);
        case (target)
            0:       return model_vram1[addr[VRAM_AW-1:0]];
            1:       return model_vram2[addr[VRAM_AW-1:0]];
            2:       return model_cfg1[addr[2:0]];
            3:       return model_cfg2[addr[2:0]];
            default: return model_pal[addr[7:0]];  // Palette base has zero low byte
        endcase
    endfunction

    task automatic drive_host(input logic we, input logic rd, input int target,
                              input vid_bus_pkg::cpu_addr_t addr,
                              input vid_bus_pkg::byte_t wdata);
        host_we           <= we;
        host_rd           <= rd;
        host_addr         <= addr;
        host_wdata        <= wdata;
        host_gfx1_vram_cs <= (target == 0);
        host_gfx2_vram_cs <= (target == 1);
        host_gfx1_cfg_cs  <= (target == 2);
        host_gfx2_cfg_cs  <= (target == 3);
        host_pal_cs       <= (target == 4);
    endtask

    task automatic host_write(input int target, input vid_bus_pkg::cpu_addr_t addr,
                              input vid_bus_pkg::byte_t wdata);
        @(posedge clk);
        drive_host(1'b1, 1'b0, target, addr, wdata);
        @(posedge clk);
        drive_host(1'b0, 1'b0, -1, '0, '0);        // Single cycle strobe
        case (target)
            0:       model_vram1[addr[VRAM_AW-1:0]] = wdata;
            1:       model_vram2[addr[VRAM_AW-1:0]] = wdata;
            2:       model_cfg1[addr[2:0]] = wdata;
            3:       model_cfg2[addr[2:0]] = wdata;
            default: model_pal[addr[7:0]] = wdata;
        endcase
    endtask

    task automatic host_read(input int target, input vid_bus_pkg::cpu_addr_t addr);
        vid_bus_pkg::byte_t exp;
        exp = model_read(target, addr);
        @(posedge clk);
        drive_host(1'b0, 1'b1, target, addr, '0);
        @(posedge clk);
        drive_host(1'b0, 1'b0, -1, '0, '0);
        @(posedge clk);                             // Data two cycles after the strobe
        @(negedge clk);
        check_value($sformatf("host_rdata target %0d addr %h", target, addr), host_rdata, exp);
    endtask

    task automatic check_color(input vid_gfx_pkg::pal_idx_t idx);
        vid_gfx_pkg::color_t exp;
        exp = {model_pal[2 * idx + 1], model_pal[2 * idx]};  // Odd byte on top
        @(posedge clk);
        pal_idx <= idx;
        @(posedge clk);
        @(negedge clk);
        check_value($sformatf("color idx %h", idx), color, exp);
    endtask

    initial begin
        int                     cycles;
        logic                   done_seen;
        int                     target;
        vid_bus_pkg::cpu_addr_t addr;
        logic [31:0]            raw;
        logic                   is_write;

        rst = 1'b1;
        snap_data = '0;
        pal_idx = '0;
        drive_host(1'b0, 1'b0, -1, '0, '0);

        // Fill the snapshot and build the model by the layout rule
        rng = 32'd82;
        for (int i = 0; i < 2 ** SNAP_AW; i++) begin
            rng = xorshift32(rng);
            snap_mem[i] = rng[7:0];
        end
        for (int i = 0; i < V; i++) begin
            model_vram1[i] = snap_mem[i];
            model_vram2[i] = snap_mem[V + i];
        end
        for (int i = 0; i < PAL_LEN; i++) begin
            model_pal[i] = snap_mem[2 * V + i];
        end
        for (int r = 0; r < 8; r++) begin
            model_cfg2[r] = snap_mem[CFG_BASE + r];  // Chip 2 set comes first
            model_cfg1[r] = snap_mem[CFG_BASE + 8 + r];
        end

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Load time in clock edges after reset release
        cycles = 0;
        done_seen = 1'b0;
        while (!done_seen) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            done_seen = done;
        end
        check_value("done latency", cycles, N + 2);

        for (int i = 0; i < V; i++) begin
            host_read(0, vid_bus_pkg::cpu_addr_t'(i));
            host_read(1, vid_bus_pkg::cpu_addr_t'(i));
        end
        for (int r = 0; r < 8; r++) begin
            host_read(2, vid_bus_pkg::cpu_addr_t'(r));
            host_read(3, vid_bus_pkg::cpu_addr_t'(r));
        end
        for (int i = 0; i < PAL_LEN; i++) begin
            host_read(4, vid_bus_pkg::PAL_BASE + vid_bus_pkg::cpu_addr_t'(i));
        end
        for (int k = 0; k < NUM_COLOR; k++) begin
            rng = xorshift32(rng);
            check_color(rng[6:0]);
        end

        // Random host traffic with upper address bits left random for VRAM and config
        for (int k = 0; k < NUM_RAND; k++) begin
            rng = xorshift32(rng);
            target = int'(rng % 5);
            rng = xorshift32(rng);
            raw = rng;
            is_write = raw[31];
            if (target == 4) begin
                addr = vid_bus_pkg::PAL_BASE + vid_bus_pkg::cpu_addr_t'(raw[7:0]);
            end else begin
                addr = raw[12:0];
            end
            if (is_write) begin
                host_write(target, addr, raw[23:16]);
            end else begin
                host_read(target, addr);
            end
        end

        $display("test passed");
        $finish;
    end

endmodule

// ==== verilog/vid_snap_top.sv ====
// Top level of the video write path, joins the snapshot loader to both graphics chips and the palette
module vid_snap_top #(
    parameter int VRAM_AW = 13,                     // VRAM address bits per chip
    parameter int SNAP_AW = 15                      // Snapshot address bits
) (
    input  logic                   clk,
    input  logic                   rst,
    // Snapshot memory outside the design
    output logic [SNAP_AW-1:0]     snap_addr,
    input  vid_bus_pkg::byte_t     snap_data,
    // Host bus
    input  vid_bus_pkg::cpu_addr_t host_addr,
    input  vid_bus_pkg::byte_t     host_wdata,
    input  logic                   host_we,
    input  logic                   host_rd,
    input  logic                   host_gfx1_vram_cs,
    input  logic                   host_gfx2_vram_cs,
    input  logic                   host_gfx1_cfg_cs,
    input  logic                   host_gfx2_cfg_cs,
    input  logic                   host_pal_cs,
    output vid_bus_pkg::byte_t     host_rdata,
    output logic                   done,           // Snapshot loaded, host owns the bus
    // Video colour lookup
    input  vid_gfx_pkg::pal_idx_t  pal_idx,
    output vid_gfx_pkg::color_t    color
);

    // Internal CPU bus
    vid_bus_pkg::cpu_addr_t bus_addr;
    vid_bus_pkg::byte_t     bus_wdata;
    logic                   bus_we;
    logic                   gfx1_vram_cs;
    logic                   gfx2_vram_cs;
    logic                   gfx1_cfg_cs;
    logic                   gfx2_cfg_cs;
    logic                   pal_cs;

    // Read data back to the loader
    vid_bus_pkg::byte_t     gfx1_rdata;
    vid_bus_pkg::byte_t     gfx2_rdata;
    vid_bus_pkg::byte_t     pal_rdata;

    snap_loader #(
        .VRAM_AW (VRAM_AW),
        .SNAP_AW (SNAP_AW)
    ) snap_loader_i (
        .clk               (clk),
        .rst               (rst),
        .snap_addr         (snap_addr),
        .snap_data         (snap_data),
        .host_addr         (host_addr),
        .host_wdata        (host_wdata),
        .host_we           (host_we),
        .host_rd           (host_rd),
        .host_gfx1_vram_cs (host_gfx1_vram_cs),
        .host_gfx2_vram_cs (host_gfx2_vram_cs),
        .host_gfx1_cfg_cs  (host_gfx1_cfg_cs),
        .host_gfx2_cfg_cs  (host_gfx2_cfg_cs),
        .host_pal_cs       (host_pal_cs),
        .host_rdata        (host_rdata),
        .bus_addr          (bus_addr),
        .bus_wdata         (bus_wdata),
        .bus_we            (bus_we),
        .gfx1_vram_cs      (gfx1_vram_cs),
        .gfx2_vram_cs      (gfx2_vram_cs),
        .gfx1_cfg_cs       (gfx1_cfg_cs),
        .gfx2_cfg_cs       (gfx2_cfg_cs),
        .pal_cs            (pal_cs),
        .gfx1_rdata        (gfx1_rdata),
        .gfx2_rdata        (gfx2_rdata),
        .pal_rdata         (pal_rdata),
        .done              (done)
    );

    // Graphics chip 1
    gfx_chip_regs #(
        .VRAM_AW (VRAM_AW)
    ) gfx1_i (
        .clk       (clk),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_we    (bus_we),
        .vram_cs   (gfx1_vram_cs),
        .cfg_cs    (gfx1_cfg_cs),
        .rd_data   (gfx1_rdata)
    );

    // Graphics chip 2
    gfx_chip_regs #(
        .VRAM_AW (VRAM_AW)
    ) gfx2_i (
        .clk       (clk),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_we    (bus_we),
        .vram_cs   (gfx2_vram_cs),
        .cfg_cs    (gfx2_cfg_cs),
        .rd_data   (gfx2_rdata)
    );

    palette_ram palette_ram_i (
        .clk       (clk),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_we    (bus_we),
        .pal_cs    (pal_cs),
        .rd_data   (pal_rdata),
        .pal_idx   (pal_idx),
        .color     (color)
    );

endmodule

// ==== verilog/snap_loader.sv ====
// Streams the video snapshot into both graphics chips and the palette, then hands the bus to the host
module snap_loader #(
    parameter int VRAM_AW = 13,                     // VRAM address bits per chip
    parameter int SNAP_AW = 15                      // Snapshot address bits
) (
    input  logic                  clk,
    input  logic                  rst,
    // Snapshot byte port, one cycle of read latency
    output logic [SNAP_AW-1:0]    snap_addr,
    input  vid_bus_pkg::byte_t    snap_data,
    // Host bus, only honoured once done is up
    input  vid_bus_pkg::cpu_addr_t host_addr,
    input  vid_bus_pkg::byte_t    host_wdata,
    input  logic                  host_we,
    input  logic                  host_rd,
    input  logic                  host_gfx1_vram_cs,
    input  logic                  host_gfx2_vram_cs,
    input  logic                  host_gfx1_cfg_cs,
    input  logic                  host_gfx2_cfg_cs,
    input  logic                  host_pal_cs,
    output vid_bus_pkg::byte_t    host_rdata,
    // Internal bus towards the targets
    output vid_bus_pkg::cpu_addr_t bus_addr,
    output vid_bus_pkg::byte_t    bus_wdata,
    output logic                  bus_we,
    output logic                  gfx1_vram_cs,
    output logic                  gfx2_vram_cs,
    output logic                  gfx1_cfg_cs,
    output logic                  gfx2_cfg_cs,
    output logic                  pal_cs,
    // Read data back from the targets
    input  vid_bus_pkg::byte_t    gfx1_rdata,
    input  vid_bus_pkg::byte_t    gfx2_rdata,
    input  vid_bus_pkg::byte_t    pal_rdata,
    output logic                  done
);

    localparam int VRAM_LEN = 2 ** VRAM_AW;
    localparam int PAL_LEN  = 256;
    localparam int SNAP_LEN = 2 * VRAM_LEN + PAL_LEN + vid_bus_pkg::SNAP_CFG_BYTES;

    // Region offset must reach the palette size even with tiny VRAMs
    localparam int OFF_W = (VRAM_AW > 8) ? VRAM_AW : 8;

    localparam logic [SNAP_AW-1:0] SNAP_LAST = SNAP_AW'(SNAP_LEN - 1);
    localparam logic [OFF_W-1:0]   VRAM_LAST = OFF_W'(VRAM_LEN - 1);
    localparam logic [OFF_W-1:0]   PAL_LAST  = OFF_W'(PAL_LEN - 1);
    localparam logic [OFF_W-1:0]   CFG_LAST  = OFF_W'(vid_bus_pkg::SNAP_CFG_BYTES - 1);
    localparam logic [OFF_W-1:0]   CFG_SPLIT = OFF_W'(vid_bus_pkg::CFG_REGS);

    // Region of the byte on the write stage
    typedef enum logic [2:0] {
        LOAD_GFX1,
        LOAD_GFX2,
        LOAD_PAL,
        LOAD_CFG,
        RUN
    } load_state_t;

    load_state_t state;

    logic                   fetching;   // Snapshot addresses still being issued
    logic                   fetch_vld;  // snap_data holds a byte this cycle
    logic [OFF_W-1:0]       off;        // Byte offset inside the current region
    logic                   off_last;   // Last byte of the current region

    // Next bus cycle, registered below
    vid_bus_pkg::cpu_addr_t nxt_addr;
    vid_bus_pkg::byte_t     nxt_wdata;
    logic                   nxt_we;
    logic                   nxt_gfx1_vram_cs;
    logic                   nxt_gfx2_vram_cs;
    logic                   nxt_gfx1_cfg_cs;
    logic                   nxt_gfx2_cfg_cs;
    logic                   nxt_pal_cs;
    logic                   host_acc;   // Host asks for a read or a write

    // Target read on the bus last cycle, its data is out now
    logic                   rd_gfx1;
    logic                   rd_gfx2;
    logic                   rd_pal;

    assign host_acc = host_we | host_rd;

    always_comb begin
        nxt_addr         = '0;
        nxt_wdata        = snap_data;
        nxt_we           = 1'b0;
        nxt_gfx1_vram_cs = 1'b0;
        nxt_gfx2_vram_cs = 1'b0;
        nxt_gfx1_cfg_cs  = 1'b0;
        nxt_gfx2_cfg_cs  = 1'b0;
        nxt_pal_cs       = 1'b0;
        off_last         = 1'b0;
        case (state)
            LOAD_GFX1: begin
                nxt_we           = fetch_vld;
                nxt_gfx1_vram_cs = fetch_vld;
                nxt_addr         = vid_bus_pkg::cpu_addr_t'(off[VRAM_AW-1:0]);
                off_last         = off == VRAM_LAST;
            end
            LOAD_GFX2: begin
                nxt_we           = fetch_vld;
                nxt_gfx2_vram_cs = fetch_vld;
                nxt_addr         = vid_bus_pkg::cpu_addr_t'(off[VRAM_AW-1:0]);
                off_last         = off == VRAM_LAST;
            end
            LOAD_PAL: begin
                nxt_we     = fetch_vld;
                nxt_pal_cs = fetch_vld;
                nxt_addr   = vid_bus_pkg::PAL_BASE + vid_bus_pkg::cpu_addr_t'(off[7:0]);
                off_last   = off == PAL_LAST;
            end
            LOAD_CFG: begin
                // First set in the stream belongs to chip 2
                nxt_we          = fetch_vld;
                nxt_gfx1_cfg_cs = fetch_vld & (off >= CFG_SPLIT);
                nxt_gfx2_cfg_cs = fetch_vld & (off < CFG_SPLIT);
                nxt_addr        = vid_bus_pkg::cpu_addr_t'(off[2:0]);
                off_last        = off == CFG_LAST;
            end
            default: begin
                if (done) begin             // Host pass-through
                    nxt_addr         = host_addr;
                    nxt_wdata        = host_wdata;
                    nxt_we           = host_we;
                    nxt_gfx1_vram_cs = host_gfx1_vram_cs & host_acc;
                    nxt_gfx2_vram_cs = host_gfx2_vram_cs & host_acc;
                    nxt_gfx1_cfg_cs  = host_gfx1_cfg_cs & host_acc;
                    nxt_gfx2_cfg_cs  = host_gfx2_cfg_cs & host_acc;
                    nxt_pal_cs       = host_pal_cs & host_acc;
                end
            end
        endcase
    end

    // Snapshot prefetch, one address per cycle until the end of the image
    always_ff @(posedge clk) begin
        if (rst) begin
            snap_addr <= '0;
            fetching  <= 1'b1;
            fetch_vld <= 1'b0;
        end else begin
            fetch_vld <= fetching;          // Memory answers one cycle later
            if (fetching) begin
                snap_addr <= snap_addr + 1'b1;
                if (snap_addr == SNAP_LAST) begin
                    fetching <= 1'b0;
                end
            end
        end
    end

    // Region sequencer and bus control
    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= LOAD_GFX1;
            off          <= '0;
            done         <= 1'b0;
            bus_we       <= 1'b0;
            gfx1_vram_cs <= 1'b0;
            gfx2_vram_cs <= 1'b0;
            gfx1_cfg_cs  <= 1'b0;
            gfx2_cfg_cs  <= 1'b0;
            pal_cs       <= 1'b0;
            rd_gfx1      <= 1'b0;
            rd_gfx2      <= 1'b0;
            rd_pal       <= 1'b0;
        end else begin
            if (state != RUN && fetch_vld) begin
                if (off_last) begin
                    off <= '0;
                    case (state)
                        LOAD_GFX1: state <= LOAD_GFX2;
                        LOAD_GFX2: state <= LOAD_PAL;
                        LOAD_PAL:  state <= LOAD_CFG;
                        default:   state <= RUN;
                    endcase
                end else begin
                    off <= off + 1'b1;
                end
            end
            if (state == RUN) begin
                done <= 1'b1;               // One cycle after the last load write
            end
            bus_we       <= nxt_we;
            gfx1_vram_cs <= nxt_gfx1_vram_cs;
            gfx2_vram_cs <= nxt_gfx2_vram_cs;
            gfx1_cfg_cs  <= nxt_gfx1_cfg_cs;
            gfx2_cfg_cs  <= nxt_gfx2_cfg_cs;
            pal_cs       <= nxt_pal_cs;
            // Remember who got a read, its data arrives next cycle
            rd_gfx1 <= (gfx1_vram_cs | gfx1_cfg_cs) & ~bus_we;
            rd_gfx2 <= (gfx2_vram_cs | gfx2_cfg_cs) & ~bus_we;
            rd_pal  <= pal_cs & ~bus_we;
        end
    end

    // Bus payload
    always_ff @(posedge clk) begin
        bus_addr  <= nxt_addr;
        bus_wdata <= nxt_wdata;
    end

    // Read return mux
    always_comb begin
        if (rd_gfx1) begin
            host_rdata = gfx1_rdata;
        end else if (rd_gfx2) begin
            host_rdata = gfx2_rdata;
        end else if (rd_pal) begin
            host_rdata = pal_rdata;
        end else begin
            host_rdata = '0;
        end
    end

endmodule

// ==== verilog/palette_ram.sv ====
// Palette byte RAM with a CPU port and a video colour lookup that joins two bytes into one colour
module palette_ram (
    input  logic                   clk,
    // CPU port, low 8 address bits pick the byte
    input  vid_bus_pkg::cpu_addr_t bus_addr,
    input  vid_bus_pkg::byte_t     bus_wdata,
    input  logic                   bus_we,
    input  logic                   pal_cs,
    output vid_bus_pkg::byte_t     rd_data,
    // Video lookup
    input  vid_gfx_pkg::pal_idx_t  pal_idx,
    output vid_gfx_pkg::color_t    color
);

    localparam int PAL_WORDS = 2 ** $bits(vid_gfx_pkg::pal_idx_t);

    // Even and odd bytes in separate banks so a colour reads in one cycle
    vid_bus_pkg::byte_t pal_even [0:PAL_WORDS-1];
    vid_bus_pkg::byte_t pal_odd  [0:PAL_WORDS-1];

    vid_gfx_pkg::pal_idx_t cpu_word;               // Colour the CPU byte belongs to
    logic                  cpu_odd;                // High byte of that colour

    assign cpu_word = bus_addr[7:1];
    assign cpu_odd  = bus_addr[0];

    always_ff @(posedge clk) begin
        if (bus_we && pal_cs && !cpu_odd) begin
            pal_even[cpu_word] <= bus_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (bus_we && pal_cs && cpu_odd) begin
            pal_odd[cpu_word] <= bus_wdata;
        end
    end

    // CPU read, one clock after the select
    always_ff @(posedge clk) begin
        if (pal_cs && !bus_we) begin
            rd_data <= cpu_odd ? pal_odd[cpu_word] : pal_even[cpu_word];
        end
    end

    // Colour lookup, odd byte on top
    always_ff @(posedge clk) begin
        color <= {pal_odd[pal_idx], pal_even[pal_idx]};
    end

endmodule

// ==== verilog/gfx_chip_regs.sv ====
// VRAM and configuration registers of one graphics chip, written and read over the CPU bus
module gfx_chip_regs #(
    parameter int VRAM_AW = 13                      // VRAM address bits
) (
    input  logic                   clk,
    input  vid_bus_pkg::cpu_addr_t bus_addr,
    input  vid_bus_pkg::byte_t     bus_wdata,
    input  logic                   bus_we,
    input  logic                   vram_cs,        // VRAM window select
    input  logic                   cfg_cs,         // Config register select
    output vid_bus_pkg::byte_t     rd_data
);

    localparam int CFG_IW = $bits(vid_gfx_pkg::cfg_idx_t);

    vid_bus_pkg::byte_t vram [0:2**VRAM_AW-1];
    vid_bus_pkg::byte_t cfg  [0:vid_bus_pkg::CFG_REGS-1];

    logic [VRAM_AW-1:0]    vram_addr;
    vid_gfx_pkg::cfg_idx_t cfg_idx;

    assign vram_addr = bus_addr[VRAM_AW-1:0];      // Upper address bits ignored
    assign cfg_idx   = bus_addr[CFG_IW-1:0];

    // VRAM block, kept apart so it maps onto block RAM
    always_ff @(posedge clk) begin
        if (bus_we && vram_cs) begin
            vram[vram_addr] <= bus_wdata;
        end
    end

    // Eight config bytes
    always_ff @(posedge clk) begin
        if (bus_we && cfg_cs) begin
            cfg[cfg_idx] <= bus_wdata;
        end
    end

    // Read port, data one clock after the select
    always_ff @(posedge clk) begin
        if (!bus_we) begin
            if (vram_cs) begin
                rd_data <= vram[vram_addr];
            end else if (cfg_cs) begin
                rd_data <= cfg[cfg_idx];
            end
        end
    end

endmodule

// ==== verilog/vid_gfx_pkg.sv ====
// Palette and graphics register types used by the palette RAM and the chip register files
package vid_gfx_pkg;

    // One colour word from the video side
    // Low byte comes from the even palette byte, high byte from the odd one
    typedef logic [15:0] color_t;

    // Colour index, 128 colours held in 256 palette bytes
    typedef logic [6:0] pal_idx_t;

    // Config register index inside one chip
    typedef logic [2:0] cfg_idx_t;

endpackage

// ==== verilog/vid_bus_pkg.sv ====
// CPU bus widths and address map shared by the loader, the graphics chips and the palette
package vid_bus_pkg;

    // CPU side byte address, covers VRAM, palette and config space
    typedef logic [12:0] cpu_addr_t;

    // Bus data is one byte wide
    typedef logic [7:0] byte_t;

    // Palette window in the address map
    // Palette byte i answers at PAL_BASE + i
    localparam cpu_addr_t PAL_BASE = 13'hC00;

    localparam int CFG_REGS = 8;        // Config registers per graphics chip

    // Config tail of the snapshot, one register set per chip
    // Chip 2 comes first in the stream, as on the board
    localparam int SNAP_CFG_BYTES = 16;

endpackage
